// ==== source/dcache_pkg.sv ====
package dcache_pkg;

    // ----------------------------------------
    // Cache geometry
    // ----------------------------------------
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 4;
    localparam int LINE_W     = 128;
    localparam int LINE_BYTES = 16;
    localparam int WAYS       = 4;
    localparam int ADDR_W     = 32;

    typedef logic [LINE_W-1:0] line_t;

    typedef logic [WAYS-1:0] way_vec_t;  // One-hot or empty.

    // ----------------------------------------
    // Port payloads
    // ----------------------------------------
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              we;
        logic [3:0]        be;
        logic [WORD_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [ADDR_W-5:0] line_addr;  // Byte address without the line offset.
        line_t             data;
    } mem_wr_t;

endpackage

// ==== source/dcache_lru.sv ====
`timescale 1ns/1ps

module dcache_lru import dcache_pkg::*; #(
    parameter int SETS = 16
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic [$clog2(SETS)-1:0] index,
    input  way_vec_t                 valid_set,
    input  way_vec_t                 way_visit,
    output way_vec_t                 lru_way_sel
);

    // Bit 0 picks the half to replace, bit 1 ways 0/1, bit 2 ways 2/3.
    logic [SETS-1:0][2:0] tree;
    logic [2:0]           cur;
    logic [2:0]           tree_nxt;

    assign cur = tree[index];

    always_comb begin
        tree_nxt = cur;
        if (way_visit[0] || way_visit[1]) begin
            tree_nxt[0] = 1'b1;  // Point away from the visited half.
            tree_nxt[1] = way_visit[0];
        end else begin
            tree_nxt[0] = 1'b0;
            tree_nxt[2] = way_visit[2];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tree <= '0;
        end else if (|way_visit) begin
            tree[index] <= tree_nxt;
        end
    end

    always_comb begin
        lru_way_sel = '0;
        if (&valid_set) begin
            if (cur[0]) begin
                lru_way_sel[cur[2] ? 3 : 2] = 1'b1;
            end else begin
                lru_way_sel[cur[1] ? 1 : 0] = 1'b1;
            end
        end else begin
            for (int w = WAYS - 1; w >= 0; w--) begin
                if (!valid_set[w]) begin
                    lru_way_sel = way_vec_t'(1) << w;  // Lowest invalid way wins.
                end
            end
        end
    end

endmodule

// ==== source/dcache_tag_store.sv ====
`timescale 1ns/1ps

module dcache_tag_store import dcache_pkg::*; #(
    parameter int SETS = 16
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic [ADDR_W-1:0] addr,
    input  way_vec_t          tag_we,
    input  way_vec_t          dirty_we,
    input  logic              dirty_value,
    input  way_vec_t          victim_sel,
    output way_vec_t          hit,
    output logic              cache_hit,
    output way_vec_t          valid_set,
    output logic              victim_dirty,
    output logic              victim_valid,
    output logic [ADDR_W-5:0] victim_line_addr
);

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = ADDR_W - 4 - IDX_W;

    logic [TAG_W-1:0]           tags [WAYS][SETS];
    logic [WAYS-1:0][SETS-1:0]  valid;
    logic [WAYS-1:0][SETS-1:0]  dirty;
    logic [IDX_W-1:0]           index;
    logic [TAG_W-1:0]           tag;
    logic [TAG_W-1:0]           victim_tag;

    assign index = addr[4 +: IDX_W];
    assign tag   = addr[ADDR_W-1 -: TAG_W];

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (tag_we[w]) begin
                tags[w][index] <= tag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '0;
            dirty <= '0;
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (tag_we[w]) begin
                    valid[w][index] <= 1'b1;
                end
                if (dirty_we[w]) begin
                    dirty[w][index] <= dirty_value;
                end
            end
        end
    end

    // All four ways of the set are compared at once.
    always_comb begin
        victim_dirty = 1'b0;
        victim_valid = 1'b0;
        victim_tag   = '0;
        for (int w = 0; w < WAYS; w++) begin
            valid_set[w] = valid[w][index];
            hit[w]       = valid[w][index] && (tags[w][index] == tag);
            if (victim_sel[w]) begin
                victim_dirty = dirty[w][index];
                victim_valid = valid[w][index];
                victim_tag   = tags[w][index];
            end
        end
    end

    assign cache_hit        = |hit;
    assign victim_line_addr = {victim_tag, index};

endmodule

// ==== source/dcache_data_store.sv ====
`timescale 1ns/1ps

module dcache_data_store import dcache_pkg::*; #(
    parameter int SETS = 16
) (
    input  logic              clk,
    input  logic [ADDR_W-1:0] addr,
    input  way_vec_t          line_we,
    input  way_vec_t          word_we,
    input  logic [3:0]        be,
    input  logic [WORD_W-1:0] wdata,
    input  line_t             fill_line,
    input  way_vec_t          rd_way,
    output line_t             rd_line,
    output logic [WORD_W-1:0] rd_word
);

    localparam int IDX_W = $clog2(SETS);
    localparam int WSEL_W = $clog2(LINE_WORDS);

    line_t             lines [WAYS][SETS];
    logic [IDX_W-1:0]  index;
    logic [WSEL_W-1:0] word_sel;

    assign index    = addr[4 +: IDX_W];
    assign word_sel = addr[2 +: WSEL_W];

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (line_we[w]) begin
                lines[w][index] <= fill_line;
            end else if (word_we[w]) begin
                for (int b = 0; b < 4; b++) begin
                    if (be[b]) begin
                        lines[w][index][word_sel*WORD_W + b*8 +: 8] <= wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

    always_comb begin
        rd_line = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (rd_way[w]) begin
                rd_line = lines[w][index];
            end
        end
    end

    assign rd_word = rd_line[word_sel*WORD_W +: WORD_W];

endmodule

// ==== source/dcache_mem_port.sv ====
`timescale 1ns/1ps

module dcache_mem_port import dcache_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  logic              wbuf_we,
    input  mem_wr_t           victim,
    input  logic              rd_start,
    input  logic [ADDR_W-5:0] rd_addr,
    input  logic [1:0]        req_word,
    input  logic [3:0]        req_be,
    input  logic [WORD_W-1:0] req_wdata,
    input  logic              req_we,
    input  logic              mem_wr_ack,
    input  logic              mem_rd_ack,
    input  line_t             mem_rd_data,
    output logic              w_rdy,
    output logic              wb_pending,
    output logic              wrt_finish,
    output logic              fill_finish,
    output line_t             fill_line,
    output logic              mem_wr_req,
    output mem_wr_t           mem_wr,
    output logic              mem_rd_req,
    output logic [ADDR_W-5:0] mem_rd_addr
);

    logic                  rd_pend;
    logic [LINE_BYTES-1:0] merge_be;
    line_t                 merged;

    // ----------------------------------------
    // Write-back channel
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (wbuf_we) begin
            mem_wr <= victim;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mem_wr_req <= 1'b0;
            wb_pending <= 1'b0;
        end else if (wbuf_we) begin
            mem_wr_req <= 1'b1;
            wb_pending <= 1'b1;
        end else if (mem_wr_req && mem_wr_ack) begin
            mem_wr_req <= 1'b0;
        end else if (wrt_finish) begin
            wb_pending <= 1'b0;
        end
    end

    assign wrt_finish = wb_pending && !mem_wr_req && !mem_wr_ack;  // Ack has fallen.
    assign w_rdy      = !wb_pending;

    // ----------------------------------------
    // Refill channel
    // ----------------------------------------
    // The pending CPU write is folded into the line as it arrives.
    always_comb begin
        merge_be = '0;
        if (req_we) begin
            merge_be[req_word*4 +: 4] = req_be;
        end
        for (int b = 0; b < LINE_BYTES; b++) begin
            merged[b*8 +: 8] = merge_be[b] ? req_wdata[(b%4)*8 +: 8] : mem_rd_data[b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (rd_start) begin
            mem_rd_addr <= rd_addr;
        end
        if (mem_rd_req && mem_rd_ack) begin
            fill_line <= merged;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mem_rd_req  <= 1'b0;
            rd_pend     <= 1'b0;
            fill_finish <= 1'b0;
        end else begin
            fill_finish <= 1'b0;
            if (rd_start) begin
                rd_pend <= 1'b1;
            end
            if (!mem_rd_req) begin
                if ((rd_start || rd_pend) && !mem_rd_ack) begin
                    mem_rd_req <= 1'b1;  // Waits out the previous ack.
                    rd_pend    <= 1'b0;
                end
            end else if (mem_rd_ack) begin
                mem_rd_req  <= 1'b0;
                fill_finish <= 1'b1;
            end
        end
    end

    a_wr_hold: assert property (@(posedge clk) disable iff (!rstn)
        $fell(mem_wr_req) |-> $past(mem_wr_ack));

    a_rd_hold: assert property (@(posedge clk) disable iff (!rstn)
        $fell(mem_rd_req) |-> $past(mem_rd_ack));

endmodule

// ==== source/dcache_main_fsm.sv ====
`timescale 1ns/1ps

module dcache_main_fsm import dcache_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  logic     cpu_valid,
    input  logic     op_write,
    input  logic     cache_hit,
    input  logic     w_rdy,
    input  logic     fill_finish,
    input  logic     wrt_finish,
    input  logic     victim_dirty,
    input  logic     victim_valid,
    input  logic     wb_pending,
    input  way_vec_t hit,
    input  way_vec_t lru_way_sel,
    output way_vec_t way_visit,
    output logic     rbuf_we,
    output logic     wbuf_we,
    output logic     rd_start,
    output logic     data_we_word,
    output way_vec_t data_we_line,
    output way_vec_t tag_we,
    output way_vec_t dirty_we,
    output logic     dirty_value,
    output logic     rsp_valid,
    output logic     cpu_ready
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL,
        WAIT_WRITE
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   wb_done;

    assign wb_done = wrt_finish || !wb_pending;  // No write-back started counts as done.

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (cpu_valid) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                if (cache_hit) begin
                    state_nxt = cpu_valid ? LOOKUP : IDLE;
                end else if (victim_valid && victim_dirty) begin
                    state_nxt = MISS;
                end else begin
                    state_nxt = REPLACE;
                end
            end
            MISS: begin
                if (w_rdy) begin
                    state_nxt = REPLACE;
                end
            end
            REPLACE:  state_nxt = REFILL;  // Read request rises on this edge.
            REFILL: begin
                if (fill_finish) begin
                    state_nxt = WAIT_WRITE;
                end
            end
            WAIT_WRITE: begin
                if (wb_done) begin
                    state_nxt = cpu_valid ? LOOKUP : IDLE;
                end
            end
            default:  state_nxt = IDLE;
        endcase
    end

    // ----------------------------------------
    // Output decode
    // ----------------------------------------
    always_comb begin
        way_visit    = '0;
        rbuf_we      = 1'b0;
        wbuf_we      = 1'b0;
        rd_start     = 1'b0;
        data_we_word = 1'b0;
        data_we_line = '0;
        tag_we       = '0;
        dirty_we     = '0;
        dirty_value  = 1'b0;
        rsp_valid    = 1'b0;
        cpu_ready    = 1'b0;
        case (state)
            IDLE: begin
                rbuf_we   = 1'b1;
                cpu_ready = 1'b1;
            end
            LOOKUP: begin
                if (cache_hit) begin
                    rsp_valid = 1'b1;
                    cpu_ready = 1'b1;
                    rbuf_we   = 1'b1;
                    way_visit = hit;
                    if (op_write) begin
                        data_we_word = 1'b1;
                        dirty_we     = hit;
                        dirty_value  = 1'b1;
                    end
                end
            end
            MISS:     wbuf_we  = w_rdy;  // Victim line is captured here.
            REPLACE:  rd_start = 1'b1;
            REFILL: begin
                if (fill_finish) begin
                    data_we_line = lru_way_sel;
                    tag_we       = lru_way_sel;
                    dirty_we     = lru_way_sel;
                    dirty_value  = op_write;  // The line already holds the write data.
                    way_visit    = lru_way_sel;
                end
            end
            WAIT_WRITE: begin
                if (wb_done) begin
                    rsp_valid = 1'b1;
                    cpu_ready = 1'b1;
                    rbuf_we   = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // A hit answers the request that was taken on the edge before.
    a_rsp_ready: assert property (@(posedge clk) disable iff (!rstn)
        (state == LOOKUP && cache_hit) |-> $past(cpu_valid && cpu_ready));

    a_hit_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(hit));

endmodule

// ==== source/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; #(
    parameter int SETS = 16
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              cpu_valid,
    input  cpu_req_t          cpu_req,
    input  logic              mem_wr_ack,
    input  logic              mem_rd_ack,
    input  line_t             mem_rd_data,
    output logic              cpu_ready,
    output logic              rsp_valid,
    output logic [WORD_W-1:0] rdata,
    output logic              mem_wr_req,
    output mem_wr_t           mem_wr,
    output logic              mem_rd_req,
    output logic [ADDR_W-5:0] mem_rd_addr
);

    localparam int IDX_W = $clog2(SETS);

    cpu_req_t          rbuf;
    logic              rbuf_we;
    logic              wbuf_we;
    logic              rd_start;
    logic              data_we_word;
    logic              cache_hit;
    logic              dirty_value;
    logic              victim_dirty;
    logic              victim_valid;
    logic              w_rdy;
    logic              wb_pending;
    logic              wrt_finish;
    logic              fill_finish;
    logic [ADDR_W-5:0] victim_line_addr;
    way_vec_t          hit;
    way_vec_t          valid_set;
    way_vec_t          lru_way_sel;
    way_vec_t          way_visit;
    way_vec_t          data_we_line;
    way_vec_t          tag_we;
    way_vec_t          dirty_we;
    way_vec_t          rd_way;
    line_t             rd_line;
    line_t             fill_line;
    mem_wr_t           victim;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rbuf <= '0;
        end else if (rbuf_we && cpu_valid) begin
            rbuf <= cpu_req;
        end
    end

    assign rd_way = cache_hit ? hit : lru_way_sel;  // Victim way while missing.
    assign victim = '{line_addr: victim_line_addr, data: rd_line};

    dcache_main_fsm i_dcache_main_fsm (
        .clk          (clk),
        .rstn         (rstn),
        .cpu_valid    (cpu_valid),
        .op_write     (rbuf.we),
        .cache_hit    (cache_hit),
        .w_rdy        (w_rdy),
        .fill_finish  (fill_finish),
        .wrt_finish   (wrt_finish),
        .victim_dirty (victim_dirty),
        .victim_valid (victim_valid),
        .wb_pending   (wb_pending),
        .hit          (hit),
        .lru_way_sel  (lru_way_sel),
        .way_visit    (way_visit),
        .rbuf_we      (rbuf_we),
        .wbuf_we      (wbuf_we),
        .rd_start     (rd_start),
        .data_we_word (data_we_word),
        .data_we_line (data_we_line),
        .tag_we       (tag_we),
        .dirty_we     (dirty_we),
        .dirty_value  (dirty_value),
        .rsp_valid    (rsp_valid),
        .cpu_ready    (cpu_ready)
    );

    dcache_tag_store #(.SETS(SETS)) i_dcache_tag_store (
        .clk              (clk),
        .rstn             (rstn),
        .addr             (rbuf.addr),
        .tag_we           (tag_we),
        .dirty_we         (dirty_we),
        .dirty_value      (dirty_value),
        .victim_sel       (lru_way_sel),
        .hit              (hit),
        .cache_hit        (cache_hit),
        .valid_set        (valid_set),
        .victim_dirty     (victim_dirty),
        .victim_valid     (victim_valid),
        .victim_line_addr (victim_line_addr)
    );

    dcache_data_store #(.SETS(SETS)) i_dcache_data_store (
        .clk       (clk),
        .addr      (rbuf.addr),
        .line_we   (data_we_line),
        .word_we   (hit & {WAYS{data_we_word}}),
        .be        (rbuf.be),
        .wdata     (rbuf.wdata),
        .fill_line (fill_line),
        .rd_way    (rd_way),
        .rd_line   (rd_line),
        .rd_word   (rdata)
    );

    dcache_lru #(.SETS(SETS)) i_dcache_lru (
        .clk         (clk),
        .rstn        (rstn),
        .index       (rbuf.addr[4 +: IDX_W]),
        .valid_set   (valid_set),
        .way_visit   (way_visit),
        .lru_way_sel (lru_way_sel)
    );

    dcache_mem_port i_dcache_mem_port (
        .clk         (clk),
        .rstn        (rstn),
        .wbuf_we     (wbuf_we),
        .victim      (victim),
        .rd_start    (rd_start),
        .rd_addr     (rbuf.addr[ADDR_W-1:4]),
        .req_word    (rbuf.addr[3:2]),
        .req_be      (rbuf.be),
        .req_wdata   (rbuf.wdata),
        .req_we      (rbuf.we),
        .mem_wr_ack  (mem_wr_ack),
        .mem_rd_ack  (mem_rd_ack),
        .mem_rd_data (mem_rd_data),
        .w_rdy       (w_rdy),
        .wb_pending  (wb_pending),
        .wrt_finish  (wrt_finish),
        .fill_finish (fill_finish),
        .fill_line   (fill_line),
        .mem_wr_req  (mem_wr_req),
        .mem_wr      (mem_wr),
        .mem_rd_req  (mem_rd_req),
        .mem_rd_addr (mem_rd_addr)
    );

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        rstn = 1'b1;  // Released just after the last reset edge.
    end

endmodule

// ==== verif/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

    localparam int          SETS           = 4;
    localparam int          RESET_CYCLES   = 4;
    localparam int          N_RANDOM       = 400;
    localparam int          N_DIRECTED     = 14;
    localparam int          TIMEOUT_CYCLES = 40 * (N_RANDOM + N_DIRECTED) + RESET_CYCLES;
    localparam logic [31:0] BASE           = 32'h0004_2c00;  // Window of 64 lines.

    logic              clk;
    logic              rstn;
    logic              cpu_valid;
    cpu_req_t          cpu_req;
    logic              cpu_ready;
    logic              rsp_valid;
    logic [WORD_W-1:0] rdata;
    logic              mem_wr_req;
    logic              mem_wr_ack;
    mem_wr_t           mem_wr;
    logic              mem_rd_req;
    logic              mem_rd_ack;
    logic [ADDR_W-5:0] mem_rd_addr;
    line_t             mem_rd_data;

    logic [7:0]        model_mem [0:1023];
    line_t             mem_lines [0:63];
    bit                written [0:63];
    logic [31:0]       exp_q [$];
    bit                read_q [$];
    int                acc_q [$];
    logic [31:0]       lfsr_state;
    string             test_name;
    int                errors, checks, cycles, sample_cycle;
    int                rd_count, wr_count, n_acc, n_rsp;
    int                last_latency, max_latency;
    int                rd_delay, wr_delay, rd_idx, wr_idx;
    bit                rd_drop, wr_drop, accepted;
    logic [ADDR_W-5:0] last_rd_line;
    logic [31:0]       last_rdata;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(RESET_CYCLES)) i_tb_clock_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    dcache_top #(.SETS(SETS)) i_dcache_top (
        .clk         (clk),
        .rstn        (rstn),
        .cpu_valid   (cpu_valid),
        .cpu_req     (cpu_req),
        .mem_wr_ack  (mem_wr_ack),
        .mem_rd_ack  (mem_rd_ack),
        .mem_rd_data (mem_rd_data),
        .cpu_ready   (cpu_ready),
        .rsp_valid   (rsp_valid),
        .rdata       (rdata),
        .mem_wr_req  (mem_wr_req),
        .mem_wr      (mem_wr),
        .mem_rd_req  (mem_rd_req),
        .mem_rd_addr (mem_rd_addr)
    );

    // ----------------------------------------
    // Checks and random numbers
    // ----------------------------------------
    task automatic check_value(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Mismatch in %s, %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("Error in %s: %s", test_name, msg);
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // ----------------------------------------
    // Memory pattern and reference model
    // ----------------------------------------
    function automatic logic [31:0] init_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [31:0] word_addr(input int line, input int word);
        return BASE + 32'(line) * 16 + 32'(word) * 4;
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        int off;
        off = int'(addr[9:2]) * 4;
        return {model_mem[off+3], model_mem[off+2], model_mem[off+1], model_mem[off]};
    endfunction

    function automatic line_t model_line(input int idx);
        line_t l;
        for (int b = 0; b < LINE_BYTES; b++) begin
            l[b*8 +: 8] = model_mem[idx*16 + b];
        end
        return l;
    endfunction

    // ----------------------------------------
    // Per-cycle sampling and driving
    // ----------------------------------------
    task automatic observe_cpu();
        logic [31:0] exp;
        bit          is_rd;
        int          acc;
        int          off;
        if (rsp_valid) begin
            n_rsp++;
            if (exp_q.size() == 0) begin
                report_error("response pulse without an accepted request");
            end else begin
                exp   = exp_q.pop_front();
                is_rd = read_q.pop_front();
                acc   = acc_q.pop_front();
                last_latency = sample_cycle - acc;
                if (last_latency > max_latency) max_latency = last_latency;
                if (is_rd) begin
                    last_rdata = rdata;
                    check_value("read data", exp, rdata);
                end
            end
        end
        accepted = cpu_valid && cpu_ready;  // Taken on the coming edge.
        if (accepted) begin
            n_acc++;
            acc_q.push_back(sample_cycle);
            read_q.push_back(!cpu_req.we);
            exp_q.push_back(model_word(cpu_req.addr));
            if (cpu_req.we) begin
                off = int'(cpu_req.addr[9:2]) * 4;
                for (int b = 0; b < 4; b++) begin
                    if (cpu_req.be[b]) model_mem[off+b] = cpu_req.wdata[b*8 +: 8];
                end
                written[cpu_req.addr[9:4]] = 1'b1;
            end
        end
    endtask

    task automatic observe_mem();
        logic [31:0] d;
        rd_drop = !mem_rd_req && mem_rd_ack;
        wr_drop = !mem_wr_req && mem_wr_ack;
        if (mem_rd_req && !mem_rd_ack && rd_delay < 0) begin
            rand_bits(2, d);
            rd_delay = int'(d[1:0]);
            rd_count++;
            last_rd_line = mem_rd_addr;
            rd_idx = int'(mem_rd_addr[5:0]);
            if (mem_rd_addr[27:6] != BASE[31:10]) report_error("read outside the test window");
        end
        if (mem_wr_req && !mem_wr_ack && wr_delay < 0) begin
            rand_bits(2, d);
            wr_delay = int'(d[1:0]);
            wr_count++;
            wr_idx = int'(mem_wr.line_addr[5:0]);
            if (mem_wr.line_addr[27:6] != BASE[31:10]) begin
                report_error("write-back outside the test window");
            end else begin
                check_value("write-back line", model_line(wr_idx), mem_wr.data);
                if (!written[wr_idx]) report_error("write-back of a clean line");
                written[wr_idx] = 1'b0;
                mem_lines[wr_idx] = mem_wr.data;
            end
        end
    endtask

    task automatic drive_mem();
        if (rd_drop) begin
            mem_rd_ack = 1'b0;
        end else if (rd_delay == 0) begin
            mem_rd_ack  = 1'b1;
            mem_rd_data = mem_lines[rd_idx];
            rd_delay    = -1;
        end else if (rd_delay > 0) begin
            rd_delay--;
        end
        if (wr_drop) begin
            mem_wr_ack = 1'b0;
        end else if (wr_delay == 0) begin
            mem_wr_ack = 1'b1;
            wr_delay   = -1;
        end else if (wr_delay > 0) begin
            wr_delay--;
        end
    endtask

    task automatic step_cycle();
        @(negedge clk);
        sample_cycle++;
        observe_cpu();
        observe_mem();
        @(posedge clk);
        #5;
        drive_mem();
    endtask

    task automatic issue(input logic we, input logic [31:0] addr, input logic [3:0] be,
                         input logic [31:0] wdata);
        cpu_valid = 1'b1;
        cpu_req   = '{addr: addr, we: we, be: be, wdata: wdata};
        accepted  = 1'b0;
        while (!accepted) step_cycle();
    endtask

    task automatic wait_idle();
        cpu_valid = 1'b0;
        while (exp_q.size() != 0) step_cycle();
    endtask

    // ----------------------------------------
    // Timeout
    // ----------------------------------------
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        logic [31:0] pat, old;
        logic [31:0] r_gap, r_line, r_word, r_we, r_be, r_data;
        int          rd_before, wr_before;
        cpu_valid    = 1'b0;
        cpu_req      = '0;
        mem_wr_ack   = 1'b0;
        mem_rd_ack   = 1'b0;
        mem_rd_data  = '0;
        lfsr_state   = 32'd72;
        errors       = 0;
        checks       = 0;
        sample_cycle = 0;
        rd_count     = 0;
        wr_count     = 0;
        n_acc        = 0;
        n_rsp        = 0;
        rd_delay     = -1;
        wr_delay     = -1;
        rd_idx       = 0;
        wr_idx       = 0;
        max_latency  = 0;
        last_latency = 0;
        for (int l = 0; l < 64; l++) begin
            written[l] = 1'b0;
            for (int w = 0; w < LINE_WORDS; w++) begin
                pat = init_word(word_addr(l, w));
                mem_lines[l][w*32 +: 32] = pat;
                for (int b = 0; b < 4; b++) model_mem[l*16 + w*4 + b] = pat[b*8 +: 8];
            end
        end

        test_name = "reset";
        @(posedge rstn);
        @(negedge clk);
        check_value("cpu_ready", 1, cpu_ready);
        check_value("rsp_valid", 0, rsp_valid);
        check_value("mem_rd_req", 0, mem_rd_req);
        check_value("mem_wr_req", 0, mem_wr_req);
        @(posedge clk);
        #5;

        test_name = "read miss";
        rd_before = rd_count;
        issue(1'b0, word_addr(5, 1), 4'hf, 32'h0);
        wait_idle();
        check_value("pattern word", init_word(word_addr(5, 1)), last_rdata);
        check_value("read handshakes", 1, rd_count - rd_before);
        check_value("read line address", word_addr(5, 1) >> 4, last_rd_line);

        test_name = "read hit";
        rd_before = rd_count;
        wr_before = wr_count;
        max_latency = 0;
        repeat (3) issue(1'b0, word_addr(5, 1), 4'hf, 32'h0);
        wait_idle();
        check_value("hit latency", 1, max_latency);
        check_value("memory requests", 0, (rd_count - rd_before) + (wr_count - wr_before));

        test_name = "write hit";
        issue(1'b1, word_addr(5, 1), 4'b0101, 32'hdead_beef);
        issue(1'b0, word_addr(5, 1), 4'hf, 32'h0);
        wait_idle();
        old = init_word(word_addr(5, 1));
        check_value("merged word", (old & 32'hff00_ff00) | (32'hdead_beef & 32'h00ff_00ff),
                    last_rdata);

        test_name = "write miss";
        issue(1'b1, word_addr(9, 2), 4'b1010, 32'h1234_5678);
        issue(1'b0, word_addr(9, 2), 4'hf, 32'h0);
        wait_idle();
        old = init_word(word_addr(9, 2));
        check_value("merged word", (old & 32'h00ff_00ff) | (32'h1234_5678 & 32'hff00_ff00),
                    last_rdata);

        // Set 1 holds dirty lines 5 and 9; six clean fills push out all four ways.
        test_name = "eviction";
        wr_before = wr_count;
        for (int i = 0; i < 6; i++) issue(1'b0, word_addr(13 + 4*i, 0), 4'hf, 32'h0);
        wait_idle();
        check_value("write transfers", 2, wr_count - wr_before);

        test_name = "random mix";
        for (int i = 0; i < N_RANDOM; i++) begin
            rand_bits(2, r_gap);
            if (r_gap == 0) begin
                cpu_valid = 1'b0;
                step_cycle();
            end
            rand_bits(6, r_line);
            rand_bits(2, r_word);
            rand_bits(1, r_we);
            rand_bits(4, r_be);
            rand_bits(32, r_data);
            issue(r_we[0], word_addr(int'(r_line), int'(r_word)), r_be[3:0], r_data);
        end
        wait_idle();
        repeat (4) step_cycle();  // A stray pulse after the last response still counts.
        check_value("responses", n_acc, n_rsp);

        $display("Checks: %0d, errors: %0d, requests: %0d, responses: %0d",
                 checks, errors, n_acc, n_rsp);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== dcache_top.f ====
source/dcache_pkg.sv
source/dcache_lru.sv
source/dcache_tag_store.sv
source/dcache_data_store.sv
source/dcache_mem_port.sv
source/dcache_main_fsm.sv
source/dcache_top.sv
verif/tb_clock_gen.sv
verif/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - files:
      - source/dcache_pkg.sv
      - source/dcache_lru.sv
      - source/dcache_tag_store.sv
      - source/dcache_data_store.sv
      - source/dcache_mem_port.sv
      - source/dcache_main_fsm.sv
      - source/dcache_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/dcache_tb.sv
